//--- corep.sv
package corep;

    // --------------------------------------------------
    // fetch PC

    localparam int unsigned PC_WIDTH = 38;

    typedef logic [PC_WIDTH-1:0] pc38_t;

    // link address is the next sequential instruction
    localparam int unsigned INSTR_BYTES = 4;

    // --------------------------------------------------
    // return address stack

    localparam int unsigned RAS_ENTRIES = 8;

    // circular stack pointer
    typedef logic [$clog2(RAS_ENTRIES)-1:0] ras_idx_t;

    // valid count with one extra bit to reach RAS_ENTRIES
    typedef logic [$clog2(RAS_ENTRIES):0] ras_cnt_t;

    // --------------------------------------------------
    // checkpoints

    localparam int unsigned CKPT_ENTRIES = 8;

    // id is the queue slot itself
    typedef logic [$clog2(CKPT_ENTRIES)-1:0] ckpt_id_t;

    // one saved stack state
    typedef struct packed {
        ras_idx_t idx;
        ras_cnt_t cnt;
    } ras_ckpt_t;

    // --------------------------------------------------
    // predicted control-flow event kinds

    typedef enum logic [1:0] {
        BR_NONE     = 2'b00,
        BR_CALL     = 2'b01,
        BR_RET      = 2'b10,
        BR_CALL_RET = 2'b11
    } br_kind_t;

endpackage

//--- ras_if.sv
`timescale 1ns/100ps

// predictor control <-> return address stack
interface ras_if;

    // link (push) request
    logic         link_valid;
    corep::pc38_t link_pc38;

    // return (pop) request
    logic         ret_valid;

    // combinational view of the top of stack
    logic            ret_fallback;
    corep::pc38_t    ret_pc38;
    corep::ras_idx_t ret_ras_idx;
    corep::ras_cnt_t ret_ras_cnt;

    modport ctrl (
        output link_valid, link_pc38, ret_valid,
        input  ret_fallback, ret_pc38, ret_ras_idx, ret_ras_cnt
    );

    modport stack (
        input  link_valid, link_pc38, ret_valid,
        output ret_fallback, ret_pc38, ret_ras_idx, ret_ras_cnt
    );

endinterface

// checkpoint queue -> stack restore on flush
interface ras_restore_if;

    logic            update_valid;
    corep::ras_idx_t update_ras_idx;
    corep::ras_cnt_t update_ras_cnt;

    modport queue (output update_valid, update_ras_idx, update_ras_cnt);
    modport stack (input  update_valid, update_ras_idx, update_ras_cnt);

endinterface

//--- distram_1rport_1wport.sv
`timescale 1ns/100ps

module distram_1rport_1wport #(
    parameter type         DATA_T = logic [7:0],
    parameter int unsigned DEPTH  = corep::RAS_ENTRIES
) (
    input  logic            CLK,

    // asynchronous read port
    input  corep::ras_idx_t rindex,
    output DATA_T           rdata,

    // synchronous write port
    input  logic            wen,
    input  corep::ras_idx_t windex,
    input  DATA_T           wdata
);

    // --------------------------------------------------
    // storage

    DATA_T mem [DEPTH];

    // read is a plain mux on the index
    assign rdata = mem[rindex];

    always_ff @(posedge CLK) begin
        if (wen) begin
            mem[windex] <= wdata;
        end
    end

endmodule

//--- ras.sv
`timescale 1ns/100ps

module ras (
    input logic CLK,
    input logic nRST,

    // link / return requests from the predictor
    ras_if.stack ctl,

    // flush restore from the checkpoint queue
    ras_restore_if.stack rst
);

    // --------------------------------------------------
    // signals

    // stack pointer
    corep::ras_idx_t sp;
    corep::ras_idx_t next_sp;
    corep::ras_idx_t sp_plus_1;
    corep::ras_idx_t sp_minus_1;

    // valid count
    corep::ras_cnt_t count;
    corep::ras_cnt_t next_count;
    corep::ras_cnt_t count_plus_1;
    corep::ras_cnt_t count_minus_1;

    logic empty;

    // entry array ports
    logic            wr_en;
    corep::ras_idx_t wr_idx;
    corep::pc38_t    rd_data;

    // --------------------------------------------------
    // pointer and count registers

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            sp    <= '0;
            count <= '0;
        end
        else begin
            sp    <= next_sp;
            count <= next_count;
        end
    end

    assign empty      = (count == '0);
    assign sp_plus_1  = sp + corep::ras_idx_t'(1);
    assign sp_minus_1 = sp - corep::ras_idx_t'(1);

    // count sticks at full depth while the oldest entries get overwritten
    assign count_plus_1 = (count == corep::ras_cnt_t'(corep::RAS_ENTRIES)) ?
                          count : count + corep::ras_cnt_t'(1);
    assign count_minus_1 = count - corep::ras_cnt_t'(1);

    // --------------------------------------------------
    // next state with restore first

    always_comb begin
        next_sp    = sp;
        next_count = count;
        wr_en      = 1'b0;
        wr_idx     = sp;

        if (rst.update_valid) begin
            next_sp    = rst.update_ras_idx;
            next_count = rst.update_ras_cnt;
        end
        else if (ctl.link_valid && ctl.ret_valid) begin
            wr_en = 1'b1;
            if (empty) begin
                // nothing to replace so behave like a call
                wr_idx     = sp_plus_1;
                next_sp    = sp_plus_1;
                next_count = count_plus_1;
            end
            else begin
                // tail call replaces the top entry
                wr_idx = sp;
            end
        end
        else if (ctl.link_valid) begin
            wr_en      = 1'b1;
            wr_idx     = sp_plus_1;
            next_sp    = sp_plus_1;
            next_count = count_plus_1;
        end
        else if (ctl.ret_valid && !empty) begin
            next_sp    = sp_minus_1;
            next_count = count_minus_1;
        end
    end

    // top of stack always visible to the predictor
    assign ctl.ret_pc38     = rd_data;
    assign ctl.ret_fallback = empty;
    assign ctl.ret_ras_idx  = sp;
    assign ctl.ret_ras_cnt  = count;

    // --------------------------------------------------
    // entry array

    distram_1rport_1wport #(
        .DATA_T (corep::pc38_t),
        .DEPTH  (corep::RAS_ENTRIES)
    ) entry_ram_i (
        .CLK    (CLK),
        .rindex (sp),
        .rdata  (rd_data),
        .wen    (wr_en),
        .windex (wr_idx),
        .wdata  (ctl.link_pc38)
    );

endmodule

//--- ras_ckpt_queue.sv
`timescale 1ns/100ps

module ras_ckpt_queue (
    input  logic             CLK,
    input  logic             nRST,

    // new checkpoint from the predictor
    input  logic             push_valid,
    input  corep::ras_ckpt_t push_ckpt,
    output corep::ckpt_id_t  push_id,

    // in-order release
    input  logic             commit_valid,

    // rewind to a named checkpoint
    input  logic             flush_valid,
    input  corep::ckpt_id_t  flush_ckpt_id,

    output logic             full,

    // restore strobe to the stack
    ras_restore_if.queue     rst
);

    // --------------------------------------------------
    // signals

    corep::ras_ckpt_t ckpt_mem [corep::CKPT_ENTRIES];

    corep::ckpt_id_t head;
    corep::ckpt_id_t tail;
    corep::ckpt_id_t next_head;
    corep::ckpt_id_t next_tail;

    // held checkpoints from 0 to CKPT_ENTRIES
    logic [$clog2(corep::CKPT_ENTRIES):0] occupancy;
    logic [$clog2(corep::CKPT_ENTRIES):0] next_occupancy;

    // slots kept on a flush from head up to the named slot
    corep::ckpt_id_t kept;

    logic push_ok;
    logic commit_ok;

    // flush owns the cycle
    assign push_ok   = push_valid && !flush_valid;
    // commit on an empty queue is dropped
    assign commit_ok = commit_valid && !flush_valid && (occupancy != '0);

    assign kept = flush_ckpt_id - head;

    // --------------------------------------------------
    // head, tail and occupancy

    always_comb begin
        next_head      = head;
        next_tail      = tail;
        next_occupancy = occupancy;

        if (flush_valid) begin
            // named slot and every younger one are dropped
            next_tail      = flush_ckpt_id;
            next_occupancy = {1'b0, kept};
        end
        else begin
            if (push_ok) begin
                next_tail = tail + corep::ckpt_id_t'(1);
            end
            if (commit_ok) begin
                next_head = head + corep::ckpt_id_t'(1);
            end
            case ({push_ok, commit_ok})
                2'b10:   next_occupancy = occupancy + 1'b1;
                2'b01:   next_occupancy = occupancy - 1'b1;
                default: next_occupancy = occupancy;
            endcase
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            head      <= '0;
            tail      <= '0;
            occupancy <= '0;
        end
        else begin
            head      <= next_head;
            tail      <= next_tail;
            occupancy <= next_occupancy;
        end
    end

    // --------------------------------------------------
    // snapshot store

    always_ff @(posedge CLK) begin
        if (push_ok) begin
            ckpt_mem[tail] <= push_ckpt;
        end
    end

    assign push_id = tail;
    assign full    = (occupancy == corep::CKPT_ENTRIES[$clog2(corep::CKPT_ENTRIES):0]);

    // restore is read straight out of the named slot
    assign rst.update_valid   = flush_valid;
    assign rst.update_ras_idx = ckpt_mem[flush_ckpt_id].idx;
    assign rst.update_ras_cnt = ckpt_mem[flush_ckpt_id].cnt;

endmodule

//--- ras_pred_ctrl.sv
`timescale 1ns/100ps

module ras_pred_ctrl (
    input  logic             CLK,
    input  logic             nRST,

    // incoming event
    input  logic             br_valid,
    input  corep::br_kind_t  br_kind,
    input  corep::pc38_t     br_pc,
    input  logic             flush_valid,

    // checkpoint push
    input  corep::ckpt_id_t  push_id,
    output logic             push_valid,
    output corep::ras_ckpt_t push_ckpt,

    // registered response
    output logic             pred_valid,
    output corep::pc38_t     pred_target,
    output logic             pred_fallback,
    output corep::ckpt_id_t  pred_ckpt_id,

    ras_if.ctrl              ctl
);

    logic accept;
    logic is_call;
    logic is_ret;

    // events in a flush cycle are dropped
    assign accept  = br_valid && !flush_valid;
    assign is_call = (br_kind == corep::BR_CALL) || (br_kind == corep::BR_CALL_RET);
    assign is_ret  = (br_kind == corep::BR_RET) || (br_kind == corep::BR_CALL_RET);

    // --------------------------------------------------
    // stack requests

    assign ctl.link_valid = accept && is_call;
    assign ctl.ret_valid  = accept && is_ret;
    assign ctl.link_pc38  = br_pc + corep::pc38_t'(corep::INSTR_BYTES);

    // snapshot of the stack before this event
    assign push_valid    = accept;
    assign push_ckpt.idx = ctl.ret_ras_idx;
    assign push_ckpt.cnt = ctl.ret_ras_cnt;

    // --------------------------------------------------
    // response one cycle after the event

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            pred_valid    <= 1'b0;
            pred_target   <= '0;
            pred_fallback <= 1'b0;
            pred_ckpt_id  <= '0;
        end
        else begin
            pred_valid <= accept;
            if (accept) begin
                pred_target   <= ctl.ret_pc38;
                pred_fallback <= ctl.ret_fallback;
                pred_ckpt_id  <= push_id;
            end
        end
    end

endmodule

//--- ras_predictor.sv
`timescale 1ns/100ps

module ras_predictor (
    input  logic            CLK,
    input  logic            nRST,

    // predicted control-flow events
    input  logic            br_valid,
    input  corep::br_kind_t br_kind,
    input  corep::pc38_t    br_pc,

    // checkpoint release and rewind
    input  logic            commit_valid,
    input  logic            flush_valid,
    input  corep::ckpt_id_t flush_ckpt_id,

    // prediction response
    output logic            pred_valid,
    output corep::pc38_t    pred_target,
    output logic            pred_fallback,
    output corep::ckpt_id_t pred_ckpt_id,

    output logic            ckpt_full
);

    ras_if         ras_bus ();
    ras_restore_if restore_bus ();

    // checkpoint push between control and queue
    logic             push_valid;
    corep::ras_ckpt_t push_ckpt;
    corep::ckpt_id_t  push_id;

    ras_pred_ctrl ctrl_i (
        .CLK           (CLK),
        .nRST          (nRST),
        .br_valid      (br_valid),
        .br_kind       (br_kind),
        .br_pc         (br_pc),
        .flush_valid   (flush_valid),
        .push_id       (push_id),
        .push_valid    (push_valid),
        .push_ckpt     (push_ckpt),
        .pred_valid    (pred_valid),
        .pred_target   (pred_target),
        .pred_fallback (pred_fallback),
        .pred_ckpt_id  (pred_ckpt_id),
        .ctl           (ras_bus.ctrl)
    );

    ras ras_i (
        .CLK  (CLK),
        .nRST (nRST),
        .ctl  (ras_bus.stack),
        .rst  (restore_bus.stack)
    );

    ras_ckpt_queue queue_i (
        .CLK           (CLK),
        .nRST          (nRST),
        .push_valid    (push_valid),
        .push_ckpt     (push_ckpt),
        .push_id       (push_id),
        .commit_valid  (commit_valid),
        .flush_valid   (flush_valid),
        .flush_ckpt_id (flush_ckpt_id),
        .full          (ckpt_full),
        .rst           (restore_bus.queue)
    );

endmodule

//--- ras_checker_asserts.sv
`timescale 1ns/100ps

module ras_checker_asserts (
    input logic            CLK,
    input logic            nRST,
    input logic            br_valid,
    input logic            flush_valid,
    input logic            pred_valid,
    input corep::pc38_t    pred_target,
    input logic            pred_fallback,
    input corep::ckpt_id_t pred_ckpt_id,
    input logic            ckpt_full
);

    // failed assertions so far
    int unsigned failures = 0;

    // source must stay within the checkpoint depth
    no_event_when_full: assert property (
        @(posedge CLK) disable iff (!nRST) !(br_valid && ckpt_full)
    ) else begin
        failures++;
        $error("event sent while the checkpoint queue is full");
    end

    // accepted event answers on the next edge
    pred_after_event: assert property (
        @(posedge CLK) disable iff (!nRST) (br_valid && !flush_valid) |=> pred_valid
    ) else begin
        failures++;
        $error("no prediction one cycle after an accepted event");
    end

    // flush drops the event of its own cycle
    no_pred_after_flush: assert property (
        @(posedge CLK) disable iff (!nRST) flush_valid |=> !pred_valid
    ) else begin
        failures++;
        $error("prediction issued for an event dropped by a flush");
    end

    // outputs come out of reset cleared
    outputs_clear_at_reset: assert property (
        @(posedge CLK) $rose(nRST) |-> (!pred_valid && !pred_fallback && !ckpt_full
            && (pred_target == '0) && (pred_ckpt_id == '0))
    ) else begin
        failures++;
        $error("outputs not cleared when reset is released");
    end

endmodule

//--- ras_checker.sv
`timescale 1ns/100ps

module ras_checker (
    input  logic            CLK,
    input  logic            nRST,
    input  logic            br_valid,
    input  corep::br_kind_t br_kind,
    input  corep::pc38_t    br_pc,
    input  logic            commit_valid,
    input  logic            flush_valid,
    input  corep::ckpt_id_t flush_ckpt_id,
    input  logic            pred_valid,
    input  corep::pc38_t    pred_target,
    input  logic            pred_fallback,
    input  corep::ckpt_id_t pred_ckpt_id,
    input  logic            ckpt_full,
    output int unsigned     error_count
);

    // name of the running test as set by the testbench
    string test_name = "reset";

    int unsigned errors = 0;

    // --------------------------------------------------
    // reference model state

    corep::pc38_t     m_mem [corep::RAS_ENTRIES];
    corep::ras_idx_t  m_ptr;
    corep::ras_cnt_t  m_cnt;
    corep::ras_ckpt_t m_snap [corep::CKPT_ENTRIES];
    corep::ckpt_id_t  head;
    corep::ckpt_id_t  tail;
    logic [3:0]       occ;
    logic             commit_ok;

    // response due at the next compare
    logic             exp_valid;
    corep::pc38_t     exp_target;
    logic             exp_fallback;
    corep::ckpt_id_t  exp_id;
    string            exp_name;

    assign error_count = errors;

    // stack rules for one accepted event
    function automatic void apply_stack_rules(input corep::br_kind_t kind,
                                              input corep::pc38_t pc);
        corep::pc38_t    link;
        corep::ras_idx_t up;
        link = pc + corep::pc38_t'(corep::INSTR_BYTES);
        up   = m_ptr + corep::ras_idx_t'(1);
        if (kind == corep::BR_CALL || (kind == corep::BR_CALL_RET && m_cnt == '0)) begin
            m_mem[up] = link;
            m_ptr     = up;
            if (m_cnt != corep::ras_cnt_t'(corep::RAS_ENTRIES)) begin
                m_cnt = m_cnt + corep::ras_cnt_t'(1);
            end
        end
        else if (kind == corep::BR_CALL_RET) begin
            // tail call replaces the top
            m_mem[m_ptr] = link;
        end
        else if (kind == corep::BR_RET && m_cnt != '0) begin
            m_ptr = m_ptr - corep::ras_idx_t'(1);
            m_cnt = m_cnt - corep::ras_cnt_t'(1);
        end
    endfunction

    function automatic void check_value(input string name, input string what,
                                        input logic [63:0] expected, input logic [63:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("FAIL %s: %s expected 'h%0h actual 'h%0h", name, what, expected, actual);
        end
    endfunction

    // --------------------------------------------------
    // compare and then advance the model
    // inputs and outputs are both settled at the falling edge

    always @(negedge CLK) begin
        if (!nRST) begin
            m_ptr     = '0;
            m_cnt     = '0;
            head      = '0;
            tail      = '0;
            occ       = '0;
            exp_valid = 1'b0;
        end
        else begin
            if (exp_valid) begin
                check_value(exp_name, "pred_valid", 64'(1'b1), 64'(pred_valid));
                check_value(exp_name, "pred_fallback", 64'(exp_fallback), 64'(pred_fallback));
                check_value(exp_name, "pred_ckpt_id", 64'(exp_id), 64'(pred_ckpt_id));
                // target of an empty stack is undefined
                if (!exp_fallback) begin
                    check_value(exp_name, "pred_target", 64'(exp_target), 64'(pred_target));
                end
            end
            else begin
                check_value(test_name, "pred_valid", 64'(1'b0), 64'(pred_valid));
            end
            check_value(test_name, "ckpt_full", 64'(occ == 4'd8), 64'(ckpt_full));

            if (flush_valid) begin
                m_ptr     = m_snap[flush_ckpt_id].idx;
                m_cnt     = m_snap[flush_ckpt_id].cnt;
                tail      = flush_ckpt_id;
                occ       = {1'b0, flush_ckpt_id - head};
                exp_valid = 1'b0;
            end
            else begin
                commit_ok = commit_valid && (occ != 4'd0);
                exp_valid = br_valid;
                if (br_valid) begin
                    exp_target   = m_mem[m_ptr];
                    exp_fallback = (m_cnt == '0);
                    exp_id       = tail;
                    exp_name     = test_name;
                    m_snap[tail] = '{idx: m_ptr, cnt: m_cnt};
                    apply_stack_rules(br_kind, br_pc);
                    tail = tail + corep::ckpt_id_t'(1);
                    occ  = occ + 4'd1;
                end
                if (commit_ok) begin
                    head = head + corep::ckpt_id_t'(1);
                    occ  = occ - 4'd1;
                end
            end
        end
    end

endmodule

//--- tb_ras_predictor.sv
`timescale 1ns/100ps

module tb_ras_predictor;

    logic            CLK;
    logic            nRST;
    logic            br_valid;
    corep::br_kind_t br_kind;
    corep::pc38_t    br_pc;
    logic            commit_valid;
    logic            flush_valid;
    corep::ckpt_id_t flush_ckpt_id;
    logic            pred_valid;
    corep::pc38_t    pred_target;
    logic            pred_fallback;
    corep::ckpt_id_t pred_ckpt_id;
    logic            ckpt_full;

    int unsigned     checker_errors;
    int unsigned     timeouts;
    int unsigned     i;
    corep::ckpt_id_t saved_id;
    corep::ckpt_id_t fid;
    logic            do_flush;
    logic [63:0]     rand_pc;

    always #4 CLK = ~CLK;

    ras_predictor dut_i (.*);

    ras_checker checker_i (.*, .error_count(checker_errors));

    bind ras_predictor ras_checker_asserts asserts_i (
        .CLK           (CLK),
        .nRST          (nRST),
        .br_valid      (br_valid),
        .flush_valid   (flush_valid),
        .pred_valid    (pred_valid),
        .pred_target   (pred_target),
        .pred_fallback (pred_fallback),
        .pred_ckpt_id  (pred_ckpt_id),
        .ckpt_full     (ckpt_full)
    );

    // --------------------------------------------------
    // stimulus helpers

    task automatic wait_drive_point();
        @(posedge CLK);
        #1;
    endtask

    task automatic set_inputs(input logic valid, input corep::br_kind_t kind,
                              input corep::pc38_t pc, input logic commit,
                              input logic flush, input corep::ckpt_id_t id);
        br_valid      = valid;
        br_kind       = kind;
        br_pc         = pc;
        commit_valid  = commit;
        flush_valid   = flush;
        flush_ckpt_id = id;
    endtask

    // one event that commits old checkpoints to keep room
    task automatic send(input corep::br_kind_t kind, input corep::pc38_t pc);
        wait_drive_point();
        set_inputs(1'b1, kind, pc, checker_i.occ >= 4'd6, 1'b0, '0);
    endtask

    task automatic drain_queue();
        int unsigned cycles;
        cycles = 0;
        do begin
            wait_drive_point();
            set_inputs(1'b0, corep::BR_NONE, '0, checker_i.occ != 4'd0, 1'b0, '0);
            cycles++;
        end while (checker_i.occ != 4'd0 && cycles < 40);
        if (checker_i.occ != 4'd0) begin
            timeouts++;
            $display("timeout: checkpoint queue still not empty after %0d cycles", cycles);
        end
    endtask

    // idle until the last response has been compared
    task automatic wait_quiet();
        int unsigned cycles;
        cycles = 0;
        do begin
            wait_drive_point();
            set_inputs(1'b0, corep::BR_NONE, '0, 1'b0, 1'b0, '0);
            cycles++;
        end while (checker_i.exp_valid && cycles < 10);
        if (checker_i.exp_valid) begin
            timeouts++;
            $display("timeout: a prediction is still outstanding after %0d cycles", cycles);
        end
    endtask

    // --------------------------------------------------
    // test sequence

    initial begin
        CLK      = 1'b0;
        nRST     = 1'b0;
        timeouts = 0;
        set_inputs(1'b0, corep::BR_NONE, '0, 1'b0, 1'b0, '0);
        void'($urandom(13));
        repeat (2) @(posedge CLK);
        #1;
        nRST = 1'b1;

        checker_i.test_name = "nested_calls";
        send(corep::BR_CALL, 38'h100);
        send(corep::BR_CALL, 38'h200);
        send(corep::BR_CALL, 38'h300);
        repeat (3) send(corep::BR_RET, '0);

        checker_i.test_name = "empty_and_wrap";
        repeat (2) send(corep::BR_RET, '0);
        for (i = 0; i < 10; i++) begin
            send(corep::BR_CALL, corep::pc38_t'(38'h1000 + i * 16));
        end
        repeat (9) send(corep::BR_RET, '0);

        checker_i.test_name = "call_with_return";
        send(corep::BR_CALL_RET, 38'h5000);
        send(corep::BR_CALL, 38'h6000);
        send(corep::BR_CALL_RET, 38'h7000);
        repeat (3) send(corep::BR_RET, '0);

        checker_i.test_name = "flush_restore";
        drain_queue();
        // slot of the second event below
        saved_id = checker_i.tail + corep::ckpt_id_t'(1);
        send(corep::BR_CALL, 38'h8000);
        send(corep::BR_CALL, 38'h9000);
        send(corep::BR_CALL, 38'hA000);
        send(corep::BR_RET, '0);
        send(corep::BR_CALL, 38'hB000);
        wait_drive_point();
        set_inputs(1'b1, corep::BR_CALL, 38'hC000, 1'b0, 1'b1, saved_id);
        repeat (3) send(corep::BR_RET, '0);

        checker_i.test_name = "queue_full";
        drain_queue();
        for (i = 0; i < corep::CKPT_ENTRIES; i++) begin
            wait_drive_point();
            set_inputs(1'b1, corep::BR_CALL, corep::pc38_t'(38'h20000 + i * 8), 1'b0, 1'b0, '0);
        end
        drain_queue();

        checker_i.test_name = "random_mix";
        for (i = 0; i < 400; i++) begin
            wait_drive_point();
            do_flush = ($urandom % 20 == 0) && (checker_i.occ != 4'd0);
            fid      = '0;
            if (do_flush) begin
                fid = checker_i.head + corep::ckpt_id_t'($urandom % checker_i.occ);
            end
            rand_pc = {$urandom, $urandom};
            set_inputs(($urandom % 4 != 0) && (checker_i.occ < 4'd8),
                       corep::br_kind_t'($urandom % 4), corep::pc38_t'(rand_pc),
                       ($urandom % 3 == 0) && (checker_i.occ != 4'd0), do_flush, fid);
        end
        wait_quiet();

        $display("errors: %0d checker, %0d assertion, %0d timeout",
                 checker_errors, dut_i.asserts_i.failures, timeouts);
        if (checker_errors == 0 && timeouts == 0 && dut_i.asserts_i.failures == 0) begin
            $display("test passed");
        end
        else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- ras_predictor.f
corep.sv
ras_if.sv
distram_1rport_1wport.sv
ras.sv
ras_ckpt_queue.sv
ras_pred_ctrl.sv
ras_predictor.sv
ras_checker_asserts.sv
ras_checker.sv
tb_ras_predictor.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_ras_predictor \
    -f ras_predictor.f -o sim_ras_predictor \
    && ./obj_dir/sim_ras_predictor +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log 2>/dev/null
[ -s sim.log ] && ! grep -q "test failed" sim.log && echo "simulation ok" \
    || { echo "simulation failed"; exit 1; }
